/* Bender.yml */
package:
  name: textRender

sources:
  # Package first, then the blocks, then the top level
  - common/textPkg.sv
  - textRender/glyphRom.sv
  - textRender/cellLocator.sv
  - textRender/glyphRaster.sv
  - logic/textRenderTop.sv

  # Testbench with its included reference header
  - target: test
    include_dirs:
      - test
    files:
      - test/textRenderTb.sv

/* common/textPkg.sv */
package textPkg;

    //////////////////////////////////////////////////
    // Raster and cell geometry
    //////////////////////////////////////////////////

    localparam int hRes        = 640;  // Active width
    localparam int vRes        = 480;  // Active height
    localparam int cellPx      = 40;   // Cell pitch, both axes
    localparam int blockPx     = 5;    // One glyph block
    localparam int glyphBlocks = 7;    // Blocks per glyph side
    localparam int cellCols    = 16;
    localparam int cellRows    = 12;

    //////////////////////////////////////////////////
    // Shared types
    //////////////////////////////////////////////////

    typedef logic [9:0] coordT;     // Raster counter
    typedef logic [7:0] charAddrT;  // Character memory address
    typedef logic [2:0] blockIdxT;  // 0..6 glyph, 7 is the gap
    typedef logic [7:0] pixelT;

    // Output levels
    localparam pixelT pixelOn  = 8'hFF;
    localparam pixelT pixelOff = 8'h00;

    // Glyph codes as stored in character memory
    // Code 28 has no name and renders blank
    typedef enum logic [7:0] {
        glyphSpace      = 8'd0,
        glyphA          = 8'd1,
        glyphB,
        glyphC,
        glyphD,
        glyphE,
        glyphF,
        glyphG,
        glyphH,
        glyphI,
        glyphJ,
        glyphK,
        glyphL,
        glyphM,
        glyphN,
        glyphO,
        glyphP,
        glyphQ,
        glyphR,
        glyphS,
        glyphT,
        glyphU,
        glyphV,
        glyphW,
        glyphX,
        glyphY,
        glyphZ,                    // 26
        glyphSlash,                // 27
        glyphUnderscore = 8'd29
    } glyphCodeE;

endpackage

/* logic/textRenderTop.sv */
module textRenderTop (
    input  logic               clk,
    input  logic               rstN,
    input  textPkg::coordT     hCount,    // Raster position
    input  textPkg::coordT     vCount,
    input  textPkg::glyphCodeE charCode,  // From character memory, one cycle late
    output textPkg::charAddrT  charAddr,  // To character memory
    output textPkg::pixelT     pixel
);

    //////////////////////////////////////////////////
    // Stage 1 to stage 2 wires
    //////////////////////////////////////////////////

    textPkg::blockIdxT blockCol;  // Block column inside cell
    textPkg::blockIdxT blockRow;  // Block row inside cell
    bit                cellActive;

    // Stage 1
    // Counters in, cell address and block position out
    cellLocator uCellLocator (
        .clk        (clk),
        .rstN       (rstN),
        .hCount     (hCount),
        .vCount     (vCount),
        .charAddr   (charAddr),
        .blockCol   (blockCol),
        .blockRow   (blockRow),
        .cellActive (cellActive)
    );

    // Stages 2 and 3
    // Memory data meets delayed block position here
    glyphRaster uGlyphRaster (
        .clk        (clk),
        .rstN       (rstN),
        .blockCol   (blockCol),
        .blockRow   (blockRow),
        .cellActive (cellActive),
        .charCode   (charCode),
        .pixel      (pixel)
    );

    // Total latency is three clocks from counters to pixel
    // No stall path, one position per clock

endmodule

/* test/textRenderRef.svh */
`ifndef TEXT_RENDER_REF_SVH
`define TEXT_RENDER_REF_SVH

//////////////////////////////////////////////////
// Expected behavior of the renderer
//////////////////////////////////////////////////

// Cell address of an active position, row-major over 16 columns
function automatic int cellAddress(input int h, input int v);
    return (v / textPkg::cellPx) * textPkg::cellCols + (h / textPkg::cellPx);
endfunction

// 1 lit, 0 dark, -1 for letters not modelled block by block
function automatic int expectPixel(input int h, input int v, input int code);
    int col;
    int row;
    col = (h % textPkg::cellPx) / textPkg::blockPx;  // 7 is the right gap
    row = (v % textPkg::cellPx) / textPkg::blockPx;  // 7 is the bottom gap
    if (h >= textPkg::hRes || v >= textPkg::vRes)
    begin
        return 0;
    end
    if (col >= 7 || row >= 7)
    begin
        return 0;
    end
    case (code)
        textPkg::glyphUnderscore: return (row == 6) ? 1 : 0;
        textPkg::glyphSlash:      return (col + row == 6) ? 1 : 0;
        textPkg::glyphI:          return (row == 0 || row == 6 || col == 3) ? 1 : 0;
        textPkg::glyphL:          return (col == 0 || row == 6) ? 1 : 0;
        textPkg::glyphT:          return (row == 0 || col == 3) ? 1 : 0;
        default:
        begin
            // Other letters, shape unchecked
            if (code >= textPkg::glyphA && code <= textPkg::glyphZ)
            begin
                return -1;
            end
            return 0;  // Space, 28 and codes past 29
        end
    endcase
endfunction

`endif

/* test/textRenderTb.sv */
module textRenderTb;
    timeunit 1ns;
    timeprecision 1ps;

    logic               clk = 1'b0;
    logic               rstN;
    textPkg::coordT     hCount;
    textPkg::coordT     vCount;
    textPkg::glyphCodeE charCode;
    textPkg::charAddrT  charAddr;
    textPkg::pixelT     pixel;

    logic [7:0]         mem [0:255];  // Character memory contents
    textPkg::charAddrT  addrQ;        // Address seen by the memory

    // Pending pixel checks, oldest first
    int                 dueQ[$];
    textPkg::pixelT     expQ[$];
    string              nameQ[$];
    int                 hQ[$];
    int                 vQ[$];

    int                 cycCount = 0;  // Rising edges so far
    string              testName;
    bit                 addrPending;
    int                 addrExp;

    `include "textRenderRef.svh"

    textRenderTop UUT (
        .clk      (clk),
        .rstN     (rstN),
        .hCount   (hCount),
        .vCount   (vCount),
        .charCode (charCode),
        .charAddr (charAddr),
        .pixel    (pixel)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycCount <= cycCount + 1;
        addrQ    <= charAddr;  // One-cycle synchronous read
    end

    // Read data put out on the falling edge, held through the next rise
    always @(negedge clk)
    begin
        charCode <= textPkg::glyphCodeE'(mem[addrQ]);
    end

    //////////////////////////////////////////////////
    // Failure reporting
    //////////////////////////////////////////////////

    task automatic valueMismatch(input string test, input int h, input int v,
                                 input int expected, input int actual);
        $display("CHECK FAILED %s at (%0d,%0d): expected %0h, actual %0h",
                 test, h, v, expected, actual);
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////

    task automatic pushCheck(input int h, input int v, input textPkg::pixelT level,
                             input int due);
        dueQ.push_back(due);
        expQ.push_back(level);
        nameQ.push_back(testName);
        hQ.push_back(h);
        vQ.push_back(v);
    endtask

    // Queue the expected pixel and address of a position just driven
    task automatic expectFor(input int h, input int v);
        int code;
        int level;
        if (h < textPkg::hRes && v < textPkg::vRes)
        begin
            addrPending = 1'b1;
            addrExp     = cellAddress(h, v);
            code        = mem[addrExp];
        end
        else
        begin
            addrPending = 1'b0;  // Blanking address is unspecified
            code        = 0;
        end
        level = expectPixel(h, v, code);
        if (level >= 0)
        begin
            pushCheck(h, v, (level == 1) ? textPkg::pixelOn : textPkg::pixelOff, cycCount + 3);
        end
    endtask

    task automatic stepTo(input int h, input int v);
        @(negedge clk);
        if (addrPending)  // Address of the previous position
        begin
            assert (charAddr == textPkg::charAddrT'(addrExp))
            else valueMismatch({testName, " address"}, hCount, vCount, addrExp, charAddr);
        end
        hCount = textPkg::coordT'(h);
        vCount = textPkg::coordT'(v);
        expectFor(h, v);
    endtask

    task automatic holdInReset();
        @(negedge clk);
        assert (charAddr == '0)
        else valueMismatch({testName, " address"}, 0, 0, 0, charAddr);
        assert (pixel == textPkg::pixelOff)
        else valueMismatch(testName, 0, 0, textPkg::pixelOff, pixel);
        hCount = '0;
        vCount = '0;
    endtask

    task automatic drain();
        repeat (4) stepTo(1000, 1000);  // Dark positions flush the pipeline
    endtask

    task automatic fillMemory(input int mode);
        int a;
        for (a = 0; a < 256; a++)
        begin
            case (mode)
                0: mem[a] = textPkg::glyphT;
                1:
                    case ($urandom_range(0, 4))
                        0:       mem[a] = textPkg::glyphI;
                        1:       mem[a] = textPkg::glyphL;
                        2:       mem[a] = textPkg::glyphT;
                        3:       mem[a] = textPkg::glyphSlash;
                        default: mem[a] = textPkg::glyphUnderscore;
                    endcase
                2:
                    case ($urandom_range(0, 3))
                        0:       mem[a] = textPkg::glyphSpace;
                        1:       mem[a] = 8'd28;
                        2:       mem[a] = 8'($urandom_range(30, 255));
                        default: mem[a] = 8'($urandom_range(1, 26));
                    endcase
                default: mem[a] = 8'($urandom_range(1, 27));  // Non-blank only
            endcase
        end
    endtask

    //////////////////////////////////////////////////
    // Comparison process
    //////////////////////////////////////////////////

    always @(negedge clk)
    begin
        if (dueQ.size() > 0 && dueQ[0] == cycCount)
        begin
            assert (pixel == expQ[0])
            else valueMismatch(nameQ[0], hQ[0], vQ[0], expQ[0], pixel);
            void'(dueQ.pop_front());
            void'(expQ.pop_front());
            void'(nameQ.pop_front());
            void'(hQ.pop_front());
            void'(vQ.pop_front());
        end
        else if (dueQ.size() > 0 && dueQ[0] < cycCount)
        begin
            abortRun("A pixel check missed the cycle it was due in");
        end
    end

    initial
    begin
        int h;
        int v;
        int n;
        void'($urandom(48988));
        rstN        = 1'b0;
        hCount      = '0;
        vCount      = '0;
        charCode    = textPkg::glyphSpace;
        addrPending = 1'b0;
        fillMemory(0);  // T everywhere, cell 0 lights at once

        testName = "after reset";
        repeat (8) holdInReset();
        rstN = 1'b1;                 // Held position becomes the first real one
        pushCheck(0, 0, textPkg::pixelOff, cycCount + 1);
        pushCheck(0, 0, textPkg::pixelOff, cycCount + 2);
        expectFor(0, 0);
        for (v = 0; v < 10; v++)
        begin
            for (h = 0; h < 80; h++)
            begin
                stepTo(h, v);
            end
        end

        testName = "address map";
        for (n = 0; n < 400; n++)
        begin
            stepTo($urandom_range(0, 639), $urandom_range(0, 479));
        end

        drain();
        fillMemory(1);
        testName = "glyph sweep";
        for (v = 0; v < textPkg::vRes; v++)
        begin
            for (h = 0; h < textPkg::hRes; h++)
            begin
                stepTo(h, v);
            end
        end

        drain();
        fillMemory(2);
        testName = "blank codes";
        for (n = 0; n < 4000; n++)
        begin
            h = $urandom_range(0, 639);
            v = $urandom_range(0, 479);
            if (n % 2 == 0)  // Aim at the gap of a cell
            begin
                if ($urandom_range(0, 1) == 1)
                begin
                    h = 40 * $urandom_range(0, 15) + $urandom_range(35, 39);
                end
                else
                begin
                    v = 40 * $urandom_range(0, 11) + $urandom_range(35, 39);
                end
            end
            stepTo(h, v);
        end

        drain();
        fillMemory(3);
        testName = "outside area";
        for (n = 0; n < 2000; n++)
        begin
            if ($urandom_range(0, 1) == 1)
            begin
                stepTo($urandom_range(640, 1023), $urandom_range(0, 1023));
            end
            else
            begin
                stepTo($urandom_range(0, 1023), $urandom_range(480, 1023));
            end
        end
        drain();

        // Let the last checks retire
        n = 0;
        while (dueQ.size() > 0 && n < 10)
        begin
            @(posedge clk);
            n++;
        end
        if (dueQ.size() > 0)
        begin
            abortRun("Pixel checks still pending after the pipeline should have drained");
        end
        else
        begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

/* textRender/cellLocator.sv */
module cellLocator (
    input  logic              clk,
    input  logic              rstN,
    input  textPkg::coordT    hCount,
    input  textPkg::coordT    vCount,
    output textPkg::charAddrT charAddr,    // Row * 16 + column
    output textPkg::blockIdxT blockCol,    // Horizontal block in cell
    output textPkg::blockIdxT blockRow,    // Vertical block in cell
    output bit                cellActive   // Inside 640x480
);

    //////////////////////////////////////////////////
    // Cell and offset decode
    //////////////////////////////////////////////////

    logic [4:0]        cellCol;    // Up to 25 for counter overrun
    logic [4:0]        cellRow;
    logic [5:0]        offX;       // 0..39 inside cell
    logic [5:0]        offY;
    textPkg::blockIdxT blockColNext;
    textPkg::blockIdxT blockRowNext;
    logic              inArea;
    textPkg::charAddrT addrNext;

    always_comb
    begin
        // Cell index and pixel offset per axis
        cellCol = 5'(hCount / textPkg::cellPx);
        cellRow = 5'(vCount / textPkg::cellPx);
        offX    = 6'(hCount % textPkg::cellPx);
        offY    = 6'(vCount % textPkg::cellPx);

        // Offsets 35..39 land on block 7, the gap
        blockColNext = textPkg::blockIdxT'(offX / textPkg::blockPx);
        blockRowNext = textPkg::blockIdxT'(offY / textPkg::blockPx);

        inArea = (hCount < textPkg::hRes) && (vCount < textPkg::vRes);

        // Blanking positions point at cell 0
        if (inArea)
        begin
            addrNext = textPkg::charAddrT'(cellRow * textPkg::cellCols + cellCol);
        end
        else
        begin
            addrNext = '0;
        end
    end

    //////////////////////////////////////////////////
    // Stage 1 registers
    //////////////////////////////////////////////////

    // Control state
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            charAddr   <= '0;
            cellActive <= 1'b0;
        end
        else
        begin
            charAddr   <= addrNext;   // Memory sees it next edge
            cellActive <= inArea;
        end
    end

    // Block position travels with the address
    always_ff @(posedge clk)
    begin
        blockCol <= blockColNext;
        blockRow <= blockRowNext;
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Active positions never address past the 16x12 grid
    addrInGrid: assert property (
        @(posedge clk) disable iff (!rstN)
        cellActive |-> (charAddr < textPkg::charAddrT'(textPkg::cellCols * textPkg::cellRows))
    );

endmodule

/* textRender/glyphRaster.sv */
module glyphRaster (
    input  logic               clk,
    input  logic               rstN,
    input  textPkg::blockIdxT  blockCol,
    input  textPkg::blockIdxT  blockRow,
    input  bit                 cellActive,
    input  textPkg::glyphCodeE charCode,   // Arrives one clock after charAddr
    output textPkg::pixelT     pixel
);

    //////////////////////////////////////////////////
    // Stage 2 alignment
    //////////////////////////////////////////////////

    textPkg::blockIdxT  colQ;        // Delayed to match charCode
    textPkg::blockIdxT  rowQ;
    logic               activeQ;
    textPkg::glyphCodeE glyphCode;
    logic [6:0]         glyphRow;    // MSB is leftmost block
    logic [7:0]         rowPadded;   // Extra zero covers column 7
    logic               colBit;
    logic               litBit;

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            activeQ <= 1'b0;
        end
        else
        begin
            activeQ <= cellActive;
        end
    end

    always_ff @(posedge clk)
    begin
        colQ <= blockCol;
        rowQ <= blockRow;
    end

    // Memory data used as is
    assign glyphCode = charCode;

    glyphRom uGlyphRom (
        .glyphCode (glyphCode),
        .rowSel    (rowQ),
        .glyphRow  (glyphRow)
    );

    //////////////////////////////////////////////////
    // Bit select and stage 3 pixel
    //////////////////////////////////////////////////

    always_comb
    begin
        rowPadded = {glyphRow, 1'b0};
        colBit    = rowPadded[3'(textPkg::glyphBlocks) - colQ];  // Col 0 at bit 7
        litBit    = activeQ
                 && (colQ < textPkg::glyphBlocks)   // Right gap
                 && (rowQ < textPkg::glyphBlocks)   // Bottom gap
                 && colBit;
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            pixel <= textPkg::pixelOff;
        end
        else
        begin
            pixel <= litBit ? textPkg::pixelOn : textPkg::pixelOff;
        end
    end

    // Two levels only
    pixelLevel: assert property (
        @(posedge clk) disable iff (!rstN)
        (pixel == textPkg::pixelOn) || (pixel == textPkg::pixelOff)
    );

endmodule

/* textRender/glyphRom.sv */
module glyphRom (
    input  textPkg::glyphCodeE glyphCode,
    input  textPkg::blockIdxT  rowSel,    // 7 selects the gap below
    output logic [6:0]         glyphRow   // MSB is block column 0
);

    //////////////////////////////////////////////////
    // 7x7 bitmaps, row 0 first
    //////////////////////////////////////////////////

    logic [0:6][6:0] bitmap;

    always_comb
    begin
        case (glyphCode)
            textPkg::glyphA:
                bitmap = {7'b0111110, 7'b1000001, 7'b1000001, 7'b1000001,
                          7'b1111111, 7'b1000001, 7'b1000001};
            textPkg::glyphB:
                bitmap = {7'b1111110, 7'b1000001, 7'b1000001, 7'b1111110,
                          7'b1000001, 7'b1000001, 7'b1111110};
            textPkg::glyphC:
                bitmap = {7'b1111111, 7'b1000000, 7'b1000000, 7'b1000000,
                          7'b1000000, 7'b1000000, 7'b1111111};
            textPkg::glyphD:
                bitmap = {7'b1111110, 7'b1000001, 7'b1000001, 7'b1000001,
                          7'b1000001, 7'b1000001, 7'b1111110};
            textPkg::glyphE:                                   // Short middle bar
                bitmap = {7'b1111111, 7'b1000000, 7'b1000000, 7'b1111100,
                          7'b1000000, 7'b1000000, 7'b1111111};
            textPkg::glyphF:
                bitmap = {7'b1111111, 7'b1000000, 7'b1000000, 7'b1111111,
                          7'b1000000, 7'b1000000, 7'b1000000};
            textPkg::glyphG:
                bitmap = {7'b1111111, 7'b1000000, 7'b1000000, 7'b1111111,
                          7'b1000001, 7'b1000001, 7'b1111111};
            textPkg::glyphH:
                bitmap = {7'b1000001, 7'b1000001, 7'b1000001, 7'b1111111,
                          7'b1000001, 7'b1000001, 7'b1000001};
            textPkg::glyphI:                                   // Bars rows 0 and 6, stem col 3
                bitmap = {7'b1111111, 7'b0001000, 7'b0001000, 7'b0001000,
                          7'b0001000, 7'b0001000, 7'b1111111};
            textPkg::glyphJ:
                bitmap = {7'b1111111, 7'b0001000, 7'b0001000, 7'b1001000,
                          7'b1001000, 7'b1001000, 7'b1111000};
            textPkg::glyphK:
                bitmap = {7'b1000001, 7'b1000010, 7'b1000100, 7'b1111000,
                          7'b1000100, 7'b1000010, 7'b1000001};
            textPkg::glyphL:                                   // Col 0 plus row 6
                bitmap = {7'b1000000, 7'b1000000, 7'b1000000, 7'b1000000,
                          7'b1000000, 7'b1000000, 7'b1111111};
            textPkg::glyphM:
                bitmap = {7'b1000001, 7'b1100011, 7'b1010101, 7'b1001001,
                          7'b1000001, 7'b1000001, 7'b1000001};
            textPkg::glyphN:
                bitmap = {7'b1000001, 7'b1100001, 7'b1010001, 7'b1001001,
                          7'b1000101, 7'b1000011, 7'b1000001};
            textPkg::glyphO:
                bitmap = {7'b1111111, 7'b1000001, 7'b1000001, 7'b1000001,
                          7'b1000001, 7'b1000001, 7'b1111111};
            textPkg::glyphP:
                bitmap = {7'b1111111, 7'b1000001, 7'b1000001, 7'b1111111,
                          7'b1000000, 7'b1000000, 7'b1000000};
            textPkg::glyphQ:                                   // Tail off lower right
                bitmap = {7'b1111111, 7'b1000001, 7'b1000001, 7'b1000001,
                          7'b1111111, 7'b0000010, 7'b0000001};
            textPkg::glyphR:
                bitmap = {7'b1111111, 7'b1000001, 7'b1000001, 7'b1111110,
                          7'b1000001, 7'b1000001, 7'b1000001};
            textPkg::glyphS:
                bitmap = {7'b1111111, 7'b1000000, 7'b1000000, 7'b1111111,
                          7'b0000001, 7'b0000001, 7'b1111111};
            textPkg::glyphT:                                   // Row 0 plus col 3
                bitmap = {7'b1111111, 7'b0001000, 7'b0001000, 7'b0001000,
                          7'b0001000, 7'b0001000, 7'b0001000};
            textPkg::glyphU:
                bitmap = {7'b1000001, 7'b1000001, 7'b1000001, 7'b1000001,
                          7'b1000001, 7'b1000001, 7'b1111111};
            textPkg::glyphV:
                bitmap = {7'b1000001, 7'b1000001, 7'b1000001, 7'b1000001,
                          7'b0100010, 7'b0010100, 7'b0001000};
            textPkg::glyphW:
                bitmap = {7'b1000001, 7'b1000001, 7'b1001001, 7'b1001001,
                          7'b1001001, 7'b1001001, 7'b1111111};
            textPkg::glyphX:
                bitmap = {7'b1000001, 7'b0100010, 7'b0010100, 7'b0001000,
                          7'b0010100, 7'b0100010, 7'b1000001};
            textPkg::glyphY:
                bitmap = {7'b1000001, 7'b0100010, 7'b0010100, 7'b0001000,
                          7'b0001000, 7'b0001000, 7'b0001000};
            textPkg::glyphZ:
                bitmap = {7'b1111111, 7'b0000010, 7'b0000100, 7'b0001000,
                          7'b0010000, 7'b0100000, 7'b1111111};

            // Column plus row equals 6
            textPkg::glyphSlash:
                bitmap = {7'b0000001, 7'b0000010, 7'b0000100, 7'b0001000,
                          7'b0010000, 7'b0100000, 7'b1000000};

            // Bottom row only
            textPkg::glyphUnderscore:
                bitmap = {7'b0000000, 7'b0000000, 7'b0000000, 7'b0000000,
                          7'b0000000, 7'b0000000, 7'b1111111};

            // Space, code 28 and anything above 29
            default:
                bitmap = '0;
        endcase

        // Gap row below the glyph
        if (rowSel < textPkg::glyphBlocks)
        begin
            glyphRow = bitmap[rowSel];
        end
        else
        begin
            glyphRow = '0;
        end
    end

endmodule

/* textRenderTop.f */
+incdir+test
common/textPkg.sv
textRender/glyphRom.sv
textRender/cellLocator.sv
textRender/glyphRaster.sv
logic/textRenderTop.sv
test/textRenderTb.sv
